/* rtl/pss_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PSS detector package: widths, window size and
// the tap tables of the three N_ID_2 sequences
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pss_pkg;

    // correlation window and CFO split point
    localparam int PSS_LEN  = 16;
    localparam int HALF_LEN = PSS_LEN / 2;

    // number of candidate N_ID_2 sequences
    localparam int N_SEQ = 3;

    // sample word is {im, re}, each SAMPLE_W bits signed
    localparam int SAMPLE_W = 8;

    // tap components, signed
    localparam int TAP_W = 4;

    // product width plus one bit for the complex add, log2 growth over
    // the window, and one spare bit so no sum can overflow
    localparam int ACC_W = SAMPLE_W + TAP_W + 1 + $clog2(PSS_LEN) + 1;

    // unsigned magnitude estimate
    localparam int METRIC_W = ACC_W;

    localparam int CNT_W = 16;
    localparam int NID_W = 2;

    // tap tables, indexed [sequence][position]
    // position 0 multiplies the newest sample in the window
    localparam logic signed [TAP_W-1:0] TAP_RE [N_SEQ][PSS_LEN] = '{
        '{ 4'sd3, -4'sd1,  4'sd2, -4'sd3,  4'sd1,  4'sd3, -4'sd2, -4'sd1,
           4'sd2,  4'sd3, -4'sd3,  4'sd1, -4'sd1, -4'sd2,  4'sd3,  4'sd2},
        '{-4'sd2,  4'sd3,  4'sd1,  4'sd3, -4'sd3, -4'sd1,  4'sd2, -4'sd2,
           4'sd3, -4'sd1, -4'sd2,  4'sd2,  4'sd1,  4'sd3, -4'sd1, -4'sd3},
        '{ 4'sd1,  4'sd2,  4'sd3, -4'sd2, -4'sd1, -4'sd3,  4'sd3,  4'sd2,
          -4'sd3,  4'sd1,  4'sd2, -4'sd1,  4'sd3, -4'sd2, -4'sd3,  4'sd1}
    };

    localparam logic signed [TAP_W-1:0] TAP_IM [N_SEQ][PSS_LEN] = '{
        '{ 4'sd1,  4'sd3, -4'sd2, -4'sd1,  4'sd3, -4'sd2, -4'sd3,  4'sd2,
          -4'sd1,  4'sd2,  4'sd1, -4'sd3,  4'sd3,  4'sd1, -4'sd2,  4'sd3},
        '{ 4'sd3,  4'sd1, -4'sd3, -4'sd2, -4'sd1,  4'sd2,  4'sd3,  4'sd1,
          -4'sd2, -4'sd3,  4'sd2,  4'sd3, -4'sd3,  4'sd1,  4'sd2, -4'sd1},
        '{-4'sd3,  4'sd2,  4'sd1,  4'sd3, -4'sd2,  4'sd1, -4'sd1, -4'sd3,
           4'sd2,  4'sd3, -4'sd1, -4'sd2,  4'sd1,  4'sd3,  4'sd2, -4'sd3}
    };

    // the rows are short pseudo-random QPSK-like patterns with no
    // conjugate symmetry, so all correlators use full multiplication

endpackage

/* rtl/pss_sample_window.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample window: shift register of the last PSS_LEN samples
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pss_sample_window import pss_pkg::*; (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic [2*SAMPLE_W-1:0]        sample_i,
    input  logic                         sample_valid_i,
    output logic [PSS_LEN*SAMPLE_W-1:0]  win_re_o,
    output logic [PSS_LEN*SAMPLE_W-1:0]  win_im_o,
    output logic                         win_valid_o
);

    logic signed [SAMPLE_W-1:0] sample_re;
    logic signed [SAMPLE_W-1:0] sample_im;

    // imaginary part sits in the upper half of the word
    assign sample_re = sample_i[SAMPLE_W-1:0];
    assign sample_im = sample_i[2*SAMPLE_W-1:SAMPLE_W];

    // position 0 (lowest slice) is the newest sample
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            win_re_o <= '0;
            win_im_o <= '0;
        end else if (sample_valid_i) begin
            win_re_o <= {win_re_o[(PSS_LEN-1)*SAMPLE_W-1:0], sample_re};
            win_im_o <= {win_im_o[(PSS_LEN-1)*SAMPLE_W-1:0], sample_im};
        end
    end

    // marks a freshly shifted window for the correlators
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            win_valid_o <= 1'b0;
        end else begin
            win_valid_o <= sample_valid_i;
        end
    end

endmodule

/* rtl/pss_correlator.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one correlator branch: complex sum, CFO half sums, magnitude
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pss_correlator import pss_pkg::*; #(
    parameter int N_ID_2 = 0
) (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic [PSS_LEN*SAMPLE_W-1:0]  win_re_i,
    input  logic [PSS_LEN*SAMPLE_W-1:0]  win_im_i,
    input  logic                         win_valid_i,
    output logic [METRIC_W-1:0]          metric_o,
    output logic [2*ACC_W-1:0]           c0_o,
    output logic [2*ACC_W-1:0]           c1_o,
    output logic                         valid_o
);

    // per-position complex products, already at accumulator width
    logic signed [ACC_W-1:0] prod_re [PSS_LEN];
    logic signed [ACC_W-1:0] prod_im [PSS_LEN];

    logic signed [ACC_W-1:0] half_re;
    logic signed [ACC_W-1:0] half_im;
    logic signed [ACC_W-1:0] tail_re;
    logic signed [ACC_W-1:0] tail_im;
    logic signed [ACC_W-1:0] sum_re;
    logic signed [ACC_W-1:0] sum_im;

    logic [METRIC_W-1:0] abs_re;
    logic [METRIC_W-1:0] abs_im;
    logic [METRIC_W-1:0] mag;

    function automatic logic [METRIC_W-1:0] abs_val(input logic signed [ACC_W-1:0] v);
        abs_val = v[ACC_W-1] ? METRIC_W'(-v) : METRIC_W'(v);
    endfunction

    // (x_re + j x_im) * (t_re + j t_im)
    for (genvar n = 0; n < PSS_LEN; n++) begin : g_tap
        logic signed [SAMPLE_W-1:0] x_re;
        logic signed [SAMPLE_W-1:0] x_im;

        assign x_re = win_re_i[n*SAMPLE_W +: SAMPLE_W];
        assign x_im = win_im_i[n*SAMPLE_W +: SAMPLE_W];

        assign prod_re[n] = x_re * TAP_RE[N_ID_2][n] - x_im * TAP_IM[N_ID_2][n];
        assign prod_im[n] = x_re * TAP_IM[N_ID_2][n] + x_im * TAP_RE[N_ID_2][n];
    end

    // first half of the window (newest samples) goes to C0
    always_comb begin
        half_re = '0;
        half_im = '0;
        for (int n = 0; n < HALF_LEN; n++) begin
            half_re = half_re + prod_re[n];
            half_im = half_im + prod_im[n];
        end
    end

    // older half goes to C1
    always_comb begin
        tail_re = '0;
        tail_im = '0;
        for (int n = HALF_LEN; n < PSS_LEN; n++) begin
            tail_re = tail_re + prod_re[n];
            tail_im = tail_im + prod_im[n];
        end
    end

    assign sum_re = half_re + tail_re;
    assign sum_im = half_im + tail_im;

    // max + min/4 approximation of the complex magnitude
    always_comb begin
        abs_re = abs_val(sum_re);
        abs_im = abs_val(sum_im);
        if (abs_im > abs_re) begin
            mag = abs_im + (abs_re >> 2);
        end else begin
            mag = abs_re + (abs_im >> 2);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= win_valid_i;
        end
    end

    // results hold between windows
    always_ff @(posedge clk_i) begin
        if (win_valid_i) begin
            metric_o <= mag;
            c0_o     <= {half_im, half_re};
            c1_o     <= {tail_im, tail_re};
        end
    end

endmodule

/* rtl/pss_peak_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// peak control: sample count, best branch select, detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pss_peak_ctrl import pss_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic [METRIC_W-1:0]  metric0_i,
    input  logic [METRIC_W-1:0]  metric1_i,
    input  logic [METRIC_W-1:0]  metric2_i,
    input  logic [2*ACC_W-1:0]   c0_0_i,
    input  logic [2*ACC_W-1:0]   c0_1_i,
    input  logic [2*ACC_W-1:0]   c0_2_i,
    input  logic [2*ACC_W-1:0]   c1_0_i,
    input  logic [2*ACC_W-1:0]   c1_1_i,
    input  logic [2*ACC_W-1:0]   c1_2_i,
    input  logic                 branch_valid_i,
    input  logic [METRIC_W-1:0]  threshold_i,
    output logic [METRIC_W-1:0]  metric_o,
    output logic [NID_W-1:0]     n_id_2_o,
    output logic [2*ACC_W-1:0]   c0_o,
    output logic [2*ACC_W-1:0]   c1_o,
    output logic [CNT_W-1:0]     sample_index_o,
    output logic                 metric_valid_o,
    output logic                 detect_o
);

    logic [CNT_W-1:0]    cnt_q;

    logic [METRIC_W-1:0] best_metric;
    logic [NID_W-1:0]    best_nid;
    logic [2*ACC_W-1:0]  best_c0;
    logic [2*ACC_W-1:0]  best_c1;

    // strict compares keep the lower index on a tie
    always_comb begin
        best_metric = metric0_i;
        best_nid    = NID_W'(0);
        best_c0     = c0_0_i;
        best_c1     = c1_0_i;
        if (metric1_i > best_metric) begin
            best_metric = metric1_i;
            best_nid    = NID_W'(1);
            best_c0     = c0_1_i;
            best_c1     = c1_1_i;
        end
        if (metric2_i > best_metric) begin
            best_metric = metric2_i;
            best_nid    = NID_W'(2);
            best_c0     = c0_2_i;
            best_c1     = c1_2_i;
        end
    end

    // windows seen since reset; first one reports index 0
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cnt_q <= '0;
        end else if (branch_valid_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // one pulse per window, detection in the same cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            metric_valid_o <= 1'b0;
            detect_o       <= 1'b0;
        end else begin
            metric_valid_o <= branch_valid_i;
            detect_o       <= branch_valid_i && (best_metric > threshold_i);
        end
    end

    // reported values hold until the next window
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            metric_o       <= '0;
            n_id_2_o       <= '0;
            c0_o           <= '0;
            c1_o           <= '0;
            sample_index_o <= '0;
        end else if (branch_valid_i) begin
            metric_o       <= best_metric;
            n_id_2_o       <= best_nid;
            c0_o           <= best_c0;
            c1_o           <= best_c1;
            sample_index_o <= cnt_q;
        end
    end

endmodule

/* rtl/pss_detector_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PSS detector top: window, three correlators, peak control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pss_detector_top import pss_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic [2*SAMPLE_W-1:0] sample_i,
    input  logic                 sample_valid_i,
    input  logic [METRIC_W-1:0]  threshold_i,
    output logic [METRIC_W-1:0]  metric_o,
    output logic [NID_W-1:0]     n_id_2_o,
    output logic [2*ACC_W-1:0]   c0_o,
    output logic [2*ACC_W-1:0]   c1_o,
    output logic [CNT_W-1:0]     sample_index_o,
    output logic                 metric_valid_o,
    output logic                 detect_o
);

    logic [PSS_LEN*SAMPLE_W-1:0] win_re;
    logic [PSS_LEN*SAMPLE_W-1:0] win_im;
    logic                        win_valid;

    logic [METRIC_W-1:0] metric_0, metric_1, metric_2;
    logic [2*ACC_W-1:0]  c0_0, c0_1, c0_2;
    logic [2*ACC_W-1:0]  c1_0, c1_1, c1_2;
    logic                branch_valid;

    pss_sample_window u_window (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .win_re_o       (win_re),
        .win_im_o       (win_im),
        .win_valid_o    (win_valid)
    );

    // all branches share the same timing, branch 0 supplies the strobe
    pss_correlator #(.N_ID_2(0)) u_corr_0 (
        .clk_i (clk_i), .reset_ni (reset_ni),
        .win_re_i (win_re), .win_im_i (win_im), .win_valid_i (win_valid),
        .metric_o (metric_0), .c0_o (c0_0), .c1_o (c1_0), .valid_o (branch_valid)
    );

    pss_correlator #(.N_ID_2(1)) u_corr_1 (
        .clk_i (clk_i), .reset_ni (reset_ni),
        .win_re_i (win_re), .win_im_i (win_im), .win_valid_i (win_valid),
        .metric_o (metric_1), .c0_o (c0_1), .c1_o (c1_1), .valid_o ()
    );

    pss_correlator #(.N_ID_2(2)) u_corr_2 (
        .clk_i (clk_i), .reset_ni (reset_ni),
        .win_re_i (win_re), .win_im_i (win_im), .win_valid_i (win_valid),
        .metric_o (metric_2), .c0_o (c0_2), .c1_o (c1_2), .valid_o ()
    );

    pss_peak_ctrl u_ctrl (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .metric0_i      (metric_0),
        .metric1_i      (metric_1),
        .metric2_i      (metric_2),
        .c0_0_i         (c0_0),
        .c0_1_i         (c0_1),
        .c0_2_i         (c0_2),
        .c1_0_i         (c1_0),
        .c1_1_i         (c1_1),
        .c1_2_i         (c1_2),
        .branch_valid_i (branch_valid),
        .threshold_i    (threshold_i),
        .metric_o       (metric_o),
        .n_id_2_o       (n_id_2_o),
        .c0_o           (c0_o),
        .c1_o           (c1_o),
        .sample_index_o (sample_index_o),
        .metric_valid_o (metric_valid_o),
        .detect_o       (detect_o)
    );

endmodule

/* tb/pss_tb_ref.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PSS detector reference model, xorshift generator
// and sample helpers for the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PSS_TB_REF_SVH
`define PSS_TB_REF_SVH

// sample history, newest at position 0
logic signed [SAMPLE_W-1:0] hist_re [PSS_LEN] = '{default: '0};
logic signed [SAMPLE_W-1:0] hist_im [PSS_LEN] = '{default: '0};

int unsigned rng_state = 15324;
int unsigned ref_count = 0;

// expected results, one entry per sample fed
logic [METRIC_W-1:0] exp_metric [$];
logic [NID_W-1:0]    exp_nid [$];
logic [2*ACC_W-1:0]  exp_c0 [$];
logic [2*ACC_W-1:0]  exp_c1 [$];
logic [CNT_W-1:0]    exp_idx [$];
logic                exp_det [$];

function automatic int unsigned xorshift32();
    int unsigned x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// uniform value in [-amp, amp]
function automatic int rand_noise(input int amp);
    int span;
    span = 2 * amp + 1;
    return int'(xorshift32() % span) - amp;
endfunction

// packs {im, re} into one sample word
function automatic logic [2*SAMPLE_W-1:0] make_word(input int re, input int im);
    return {SAMPLE_W'(im), SAMPLE_W'(re)};
endfunction

function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
endfunction

// shifts one sample into the history and queues the expected outputs
function automatic void ref_feed(input logic [2*SAMPLE_W-1:0] word,
                                 input logic [METRIC_W-1:0] thr);
    int c0_re;
    int c0_im;
    int c1_re;
    int c1_im;
    int p_re;
    int p_im;
    int a_re;
    int a_im;
    int mag;
    int best_mag;
    int best_k;
    logic [2*ACC_W-1:0] best_c0;
    logic [2*ACC_W-1:0] best_c1;

    for (int n = PSS_LEN - 1; n > 0; n--) begin
        hist_re[n] = hist_re[n-1];
        hist_im[n] = hist_im[n-1];
    end
    hist_re[0] = word[SAMPLE_W-1:0];
    hist_im[0] = word[2*SAMPLE_W-1:SAMPLE_W];

    best_mag = -1;
    best_k   = 0;
    best_c0  = '0;
    best_c1  = '0;
    for (int k = 0; k < N_SEQ; k++) begin
        c0_re = 0;
        c0_im = 0;
        c1_re = 0;
        c1_im = 0;
        for (int n = 0; n < PSS_LEN; n++) begin
            p_re = int'(hist_re[n]) * int'(TAP_RE[k][n])
                 - int'(hist_im[n]) * int'(TAP_IM[k][n]);
            p_im = int'(hist_re[n]) * int'(TAP_IM[k][n])
                 + int'(hist_im[n]) * int'(TAP_RE[k][n]);
            if (n < HALF_LEN) begin
                c0_re += p_re;
                c0_im += p_im;
            end else begin
                c1_re += p_re;
                c1_im += p_im;
            end
        end
        a_re = abs_int(c0_re + c1_re);
        a_im = abs_int(c0_im + c1_im);
        // larger component plus a quarter of the smaller one
        if (a_im > a_re) begin
            mag = a_im + a_re / 4;
        end else begin
            mag = a_re + a_im / 4;
        end
        // only a strictly larger metric takes over, ties keep the lower index
        if (mag > best_mag) begin
            best_mag = mag;
            best_k   = k;
            best_c0  = {ACC_W'(c0_im), ACC_W'(c0_re)};
            best_c1  = {ACC_W'(c1_im), ACC_W'(c1_re)};
        end
    end

    exp_metric.push_back(METRIC_W'(best_mag));
    exp_nid.push_back(NID_W'(best_k));
    exp_c0.push_back(best_c0);
    exp_c1.push_back(best_c1);
    exp_idx.push_back(CNT_W'(ref_count));
    exp_det.push_back(best_mag > int'(thr));
    ref_count++;
endfunction

`endif

/* tb/pss_detector_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PSS detector testbench with reset, random, embedded sequence,
// gapped input and maximum threshold phases
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pss_detector_tb import pss_pkg::*; ();

    logic                  clk_i;
    logic                  reset_ni;
    logic [2*SAMPLE_W-1:0] sample_i;
    logic                  sample_valid_i;
    logic [METRIC_W-1:0]   threshold_i;
    logic [METRIC_W-1:0]   metric_o;
    logic [NID_W-1:0]      n_id_2_o;
    logic [2*ACC_W-1:0]    c0_o;
    logic [2*ACC_W-1:0]    c1_o;
    logic [CNT_W-1:0]      sample_index_o;
    logic                  metric_valid_o;
    logic                  detect_o;

    int  errors = 0;
    int  n_sent = 0;
    int  n_seen = 0;
    time exp_time [$];

    `include "pss_tb_ref.svh"

    pss_detector_top DUT (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .threshold_i    (threshold_i),
        .metric_o       (metric_o),
        .n_id_2_o       (n_id_2_o),
        .c0_o           (c0_o),
        .c1_o           (c1_o),
        .sample_index_o (sample_index_o),
        .metric_valid_o (metric_valid_o),
        .detect_o       (detect_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic report_mismatch(input string field, input logic [63:0] got,
                                   input logic [63:0] want);
        errors++;
        $display("Fail %0t: %s got 0x%0h expected 0x%0h", $time, field, got, want);
    endtask

    task automatic check_idle();
        assert (!metric_valid_o && !detect_o) else begin
            errors++;
            $display("Fail %0t: output strobe around reset", $time);
        end
        assert (metric_o == 0 && n_id_2_o == 0 && c0_o == 0 && c1_o == 0
                && sample_index_o == 0) else begin
            errors++;
            $display("Fail %0t: data outputs not zero around reset", $time);
        end
    endtask

    task automatic set_threshold(input logic [METRIC_W-1:0] thr);
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
        threshold_i    <= thr;
    endtask

    task automatic send_sample(input logic [2*SAMPLE_W-1:0] word);
        @(posedge clk_i);
        sample_i       <= word;
        sample_valid_i <= 1'b1;
        ref_feed(word, threshold_i);
        // one edge to take it, two of latency and half a period to the compare
        exp_time.push_back($time + 140);
        n_sent++;
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
    endtask

    task automatic wait_drain(input string phase);
        int cycles;
        cycles = 0;
        while (exp_metric.size() != 0 && cycles < 20) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_metric.size() != 0) begin
            errors++;
            $display("timeout: %s phase still has %0d results missing after %0d cycles",
                     phase, exp_metric.size(), cycles);
        end
    endtask

    // scaled conjugate of tap row k amid low-level noise
    task automatic send_embedded(input int k);
        for (int i = 0; i < 20; i++) begin
            send_sample(make_word(rand_noise(3), rand_noise(3)));
        end
        // oldest first so that tap n meets window position n on the last sample
        for (int j = 0; j < PSS_LEN; j++) begin
            send_sample(make_word(30 * TAP_RE[k][PSS_LEN-1-j] + rand_noise(3),
                                  -30 * TAP_IM[k][PSS_LEN-1-j] + rand_noise(3)));
        end
        assert (exp_det[$] && exp_nid[$] == NID_W'(k)) else begin
            errors++;
            $display("Fail %0t: no detection of N_ID_2 %0d at the end of its sequence",
                     $time, k);
        end
        for (int i = 0; i < 8; i++) begin
            send_sample(make_word(rand_noise(3), rand_noise(3)));
        end
        idle_cycle();
    endtask

    initial begin : main
        reset_ni       = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        threshold_i    = '0;

        // four cycles of reset with the outputs quiet during and just after
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
            if (i == 3) begin
                reset_ni <= 1'b1;
            end
            @(negedge clk_i);
            check_idle();
        end
        repeat (2) begin
            @(negedge clk_i);
            check_idle();
        end

        // back to back random samples with the threshold above any reachable metric
        set_threshold(METRIC_W'(20000));
        for (int i = 0; i < 80; i++) begin
            send_sample((2*SAMPLE_W)'(xorshift32()));
        end
        idle_cycle();
        wait_drain("random");

        set_threshold(METRIC_W'(3000));
        for (int k = 0; k < N_SEQ; k++) begin
            send_embedded(k);
            wait_drain("embedded");
        end

        // random gaps in the strobe
        set_threshold(METRIC_W'(1500));
        for (int i = 0; i < 60; i++) begin
            if (xorshift32() % 3 == 0) begin
                idle_cycle();
            end else begin
                send_sample((2*SAMPLE_W)'(xorshift32()));
            end
        end
        idle_cycle();
        wait_drain("gapped");

        set_threshold('1);
        for (int i = 0; i < 40; i++) begin
            send_sample((2*SAMPLE_W)'(xorshift32()));
        end
        idle_cycle();
        wait_drain("max threshold");

        repeat (4) @(posedge clk_i);
        assert (n_seen == n_sent) else begin
            errors++;
            $display("Fail %0t: %0d output pulses for %0d samples", $time, n_seen, n_sent);
        end
        $display("samples %0d, pulses %0d, errors %0d", n_sent, n_seen, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // compares every output pulse with the oldest expectation
    initial begin : compare
        logic [METRIC_W-1:0] e_metric;
        logic [NID_W-1:0]    e_nid;
        logic [2*ACC_W-1:0]  e_c0;
        logic [2*ACC_W-1:0]  e_c1;
        logic [CNT_W-1:0]    e_idx;
        logic                e_det;
        time                 e_time;

        forever begin
            @(negedge clk_i);
            if (reset_ni && metric_valid_o) begin
                n_seen++;
                assert (exp_metric.size() != 0) else begin
                    errors++;
                    $display("output pulse at time %0t with no sample outstanding", $time);
                end
                if (exp_metric.size() != 0) begin
                    e_metric = exp_metric.pop_front();
                    e_nid    = exp_nid.pop_front();
                    e_c0     = exp_c0.pop_front();
                    e_c1     = exp_c1.pop_front();
                    e_idx    = exp_idx.pop_front();
                    e_det    = exp_det.pop_front();
                    e_time   = exp_time.pop_front();
                    assert ($time == e_time) else report_mismatch("pulse time", $time, e_time);
                    assert (metric_o == e_metric) else report_mismatch("metric", metric_o, e_metric);
                    assert (n_id_2_o == e_nid) else report_mismatch("n_id_2", n_id_2_o, e_nid);
                    assert (c0_o == e_c0) else report_mismatch("c0", c0_o, e_c0);
                    assert (c1_o == e_c1) else report_mismatch("c1", c1_o, e_c1);
                    assert (sample_index_o == e_idx)
                        else report_mismatch("sample index", sample_index_o, e_idx);
                    assert (detect_o == e_det) else report_mismatch("detect", detect_o, e_det);
                end
            end
            assert (metric_valid_o || !detect_o) else begin
                errors++;
                $display("Fail %0t: detect_o high without metric_valid_o", $time);
            end
            if (threshold_i == '1) begin
                assert (!detect_o) else begin
                    errors++;
                    $display("Fail %0t: detect_o high with the threshold at maximum", $time);
                end
            end
        end
    end

endmodule

/* vlog.f */
+incdir+tb
rtl/pss_pkg.sv
rtl/pss_sample_window.sv
rtl/pss_correlator.sv
rtl/pss_peak_ctrl.sv
rtl/pss_detector_top.sv
tb/pss_detector_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the PSS detector testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module pss_detector_tb -o pss_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/pss_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0
